/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

  typedef enum logic [5:0] {
    R_TYPE = 6'h00,
    J      = 6'h02,
    JAL    = 6'h03,
    BEQ    = 6'h04,
    BNE    = 6'h05,
    ADDI   = 6'h08,
    ORI    = 6'h0d,
    LW     = 6'h23,
    SW     = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    F_SLL = 6'h00,
    F_SRL = 6'h02,
    F_ADD = 6'h20,
    F_SUB = 6'h22,
    F_AND = 6'h24,
    F_OR  = 6'h25,
    F_SLT = 6'h2a
  } funct_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_SLL,
    ALU_SRL
  } alu_op_e;

  typedef struct packed {
    logic       reg_write;
    logic       reg_dst;    // write rd instead of rt
    logic [1:0] alu_src;    // 0 register, 1 sign imm, 2 zero imm
    alu_op_e    alu_op;
    logic [2:0] jump;       // bit 0 j, bit 1 jal, bit 2 link write
    logic       mem_write;
    logic       mem_to_reg;
  } ctrl_t;

  typedef logic [1:0] branch_t; // bit 0 beq, bit 1 bne

  typedef struct packed {
    logic        valid;
    logic [31:0] instr;
    logic [31:0] pc_plus_4;
  } fd_t;

  typedef struct packed {
    logic        valid;
    ctrl_t       ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [4:0]  shamt;
    logic [31:0] sign_imm;
    logic [31:0] pc_plus_4;
  } de_t;

  // only the controls still needed after execute
  typedef struct packed {
    logic reg_write;
    logic mem_write;
    logic mem_to_reg;
  } em_ctrl_t;

  typedef struct packed {
    logic        valid;
    em_ctrl_t    ctrl;
    logic [31:0] alu_out;
    logic [31:0] write_data;
    logic [4:0]  write_reg;
  } em_t;

  typedef struct packed {
    logic        valid;
    logic        reg_write;
    logic        mem_to_reg;
    logic [31:0] alu_out;
    logic [31:0] read_data;
    logic [4:0]  write_reg;
  } mw_t;

  typedef enum logic [1:0] {
    FWD_REG = 2'd0,
    FWD_WB  = 2'd1,
    FWD_MEM = 2'd2
  } fwd_e_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } retire_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } store_t;

endpackage : mips_pkg

`default_nettype wire

/* rtl/control_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module control_unit (
  input  mips_pkg::opcode_e op_i,
  input  mips_pkg::funct_e  funct_i,
  output mips_pkg::ctrl_t   ctrl_o,
  output mips_pkg::branch_t branch_o
);

  import mips_pkg::*;

  always_comb begin
    ctrl_o   = '0;
    branch_o = '0;
    case (op_i)
      R_TYPE: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.reg_dst   = 1'b1;
        case (funct_i)
          F_ADD:   ctrl_o.alu_op = ALU_ADD;
          F_SUB:   ctrl_o.alu_op = ALU_SUB;
          F_AND:   ctrl_o.alu_op = ALU_AND;
          F_OR:    ctrl_o.alu_op = ALU_OR;
          F_SLT:   ctrl_o.alu_op = ALU_SLT;
          F_SLL:   ctrl_o.alu_op = ALU_SLL;
          F_SRL:   ctrl_o.alu_op = ALU_SRL;
          default: ctrl_o = '0; // unsupported funct runs as a no-op
        endcase
      end
      ADDI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_src   = 2'd1;
        ctrl_o.alu_op    = ALU_ADD;
      end
      ORI: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.alu_src   = 2'd2;
        ctrl_o.alu_op    = ALU_OR;
      end
      LW: begin
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.alu_src    = 2'd1;
        ctrl_o.alu_op     = ALU_ADD;
        ctrl_o.mem_to_reg = 1'b1;
      end
      SW: begin
        ctrl_o.alu_src   = 2'd1;
        ctrl_o.alu_op    = ALU_ADD;
        ctrl_o.mem_write = 1'b1;
      end
      BEQ:     branch_o = 2'b01; // compared in decode, the alu stays idle
      BNE:     branch_o = 2'b10;
      J:       ctrl_o.jump = 3'b001;
      JAL: begin
        ctrl_o.reg_write = 1'b1;
        ctrl_o.jump      = 3'b110;
      end
      default: ctrl_o = '0;
    endcase
  end

endmodule : control_unit

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        we_i,
  input  logic [4:0]  wa_i,
  input  logic [31:0] wd_i,
  input  logic [4:0]  ra1_i,
  input  logic [4:0]  ra2_i,
  output logic [31:0] rd1_o,
  output logic [31:0] rd2_o
);

  logic [31:0] regs [32];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && wa_i != 5'd0) begin
      regs[wa_i] <= wd_i;
    end
  end

  // writeback data passes straight through to a read of the same register
  assign rd1_o = (ra1_i == 5'd0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
  assign rd2_o = (ra2_i == 5'd0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule : reg_file

`default_nettype wire

/* rtl/fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch (
  input  logic          clk_i,
  input  logic          arst_n_i,
  input  logic          stall_f_i,
  input  logic          stall_d_i,
  input  logic          pc_src_i,
  input  logic [31:0]   pc_branch_i,
  input  logic          jump_i,
  input  logic [31:0]   jump_target_i,
  output logic [31:0]   imem_addr_o,
  input  logic [31:0]   imem_data_i,
  output mips_pkg::fd_t fd_o
);

  logic [31:0] pc_q;
  logic [31:0] pc_plus_4;
  logic [31:0] pc_next;

  assign pc_plus_4   = pc_q + 32'd4;
  assign imem_addr_o = pc_q;

  always_comb begin
    if (jump_i)
      pc_next = jump_target_i;
    else if (pc_src_i)
      pc_next = pc_branch_i;
    else
      pc_next = pc_plus_4;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i)
      pc_q <= '0;
    else if (!stall_f_i)
      pc_q <= pc_next;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fd_o <= '0;
    end else if (!stall_d_i) begin
      if (pc_src_i || jump_i)
        fd_o <= '0; // drop the wrong-path instruction, no delay slot
      else
        fd_o <= '{valid: 1'b1, instr: imem_data_i, pc_plus_4: pc_plus_4};
    end
  end

endmodule : fetch

`default_nettype wire

/* rtl/decode.sv */
`timescale 1ns/100ps
`default_nettype none

module decode (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mips_pkg::fd_t     fd_i,
  input  logic [31:0]       alu_out_m_i,
  input  logic              reg_write_w_i,
  input  logic [4:0]        write_reg_w_i,
  input  logic [31:0]       result_w_i,
  input  logic              forward_a_d_i,
  input  logic              forward_b_d_i,
  input  logic              flush_e_i,
  output mips_pkg::branch_t branch_o,
  output logic              pc_src_o,
  output logic [31:0]       pc_branch_o,
  output logic              jump_o,
  output logic [31:0]       jump_target_o,
  output logic [4:0]        rs_d_o,
  output logic [4:0]        rt_d_o,
  output mips_pkg::de_t     de_o
);

  import mips_pkg::*;

  ctrl_t       ctrl_d;
  branch_t     branch_d;
  logic [31:0] rd1;
  logic [31:0] rd2;
  logic [31:0] src_a;
  logic [31:0] src_b;
  logic [31:0] sign_imm;
  logic        equal;
  de_t         de_d;

  control_unit u_control_unit (
    .op_i(opcode_e'(fd_i.instr[31:26])),
    .funct_i(funct_e'(fd_i.instr[5:0])),
    .ctrl_o(ctrl_d),
    .branch_o(branch_d)
  );

  reg_file u_reg_file (
    .clk_i,
    .arst_n_i,
    .we_i(reg_write_w_i),
    .wa_i(write_reg_w_i),
    .wd_i(result_w_i),
    .ra1_i(fd_i.instr[25:21]),
    .ra2_i(fd_i.instr[20:16]),
    .rd1_o(rd1),
    .rd2_o(rd2)
  );

  assign rs_d_o   = fd_i.instr[25:21];
  assign rt_d_o   = fd_i.instr[20:16];
  assign sign_imm = {{16{fd_i.instr[15]}}, fd_i.instr[15:0]};

  // the writeback case is covered by the register file write-through
  assign src_a = forward_a_d_i ? alu_out_m_i : rd1;
  assign src_b = forward_b_d_i ? alu_out_m_i : rd2;
  assign equal = (src_a == src_b);

  assign branch_o    = fd_i.valid ? branch_d : '0;
  assign pc_src_o    = (branch_o[0] & equal) | (branch_o[1] & ~equal);
  assign pc_branch_o = fd_i.pc_plus_4 + {sign_imm[29:0], 2'b00};

  assign jump_o        = fd_i.valid & (ctrl_d.jump[1:0] != 2'b00);
  assign jump_target_o = {fd_i.pc_plus_4[31:28], fd_i.instr[25:0], 2'b00};

  assign de_d = '{
    valid:     fd_i.valid,
    ctrl:      fd_i.valid ? ctrl_d : ctrl_t'('0), // bubbles carry no controls
    rd1:       rd1,
    rd2:       rd2,
    rs:        fd_i.instr[25:21],
    rt:        fd_i.instr[20:16],
    rd:        fd_i.instr[15:11],
    shamt:     fd_i.instr[10:6],
    sign_imm:  sign_imm,
    pc_plus_4: fd_i.pc_plus_4
  };

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      de_o <= '0;
    end else begin
      de_o <= de_d;
      if (flush_e_i) begin
        de_o.valid <= 1'b0;
        de_o.ctrl  <= '0;
      end
    end
  end

endmodule : decode

`default_nettype wire

/* rtl/execute.sv */
`timescale 1ns/100ps
`default_nettype none

module execute (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  mips_pkg::de_t    de_i,
  input  mips_pkg::fwd_e_t forward_a_e_i,
  input  mips_pkg::fwd_e_t forward_b_e_i,
  input  logic [31:0]      alu_out_m_i,
  input  logic [31:0]      result_w_i,
  output mips_pkg::em_t    em_o,
  output logic [4:0]       write_reg_e_o
);

  import mips_pkg::*;

  function automatic logic [31:0] fwd_mux(input fwd_e_t sel, input logic [31:0] reg_val,
                                          input logic [31:0] wb_val,
                                          input logic [31:0] mem_val);
    case (sel)
      FWD_WB:  return wb_val;
      FWD_MEM: return mem_val;
      default: return reg_val;
    endcase
  endfunction

  logic [31:0] src_a;
  logic [31:0] src_b_reg;
  logic [31:0] src_b;
  logic [31:0] alu_res;
  logic [31:0] alu_out;

  assign src_a     = fwd_mux(forward_a_e_i, de_i.rd1, result_w_i, alu_out_m_i);
  assign src_b_reg = fwd_mux(forward_b_e_i, de_i.rd2, result_w_i, alu_out_m_i);

  always_comb begin
    case (de_i.ctrl.alu_src)
      2'd1:    src_b = de_i.sign_imm;
      2'd2:    src_b = {16'h0000, de_i.sign_imm[15:0]}; // ori zero-extends
      default: src_b = src_b_reg;
    endcase
  end

  always_comb begin
    case (de_i.ctrl.alu_op)
      ALU_ADD: alu_res = src_a + src_b;
      ALU_SUB: alu_res = src_a - src_b;
      ALU_AND: alu_res = src_a & src_b;
      ALU_OR:  alu_res = src_a | src_b;
      ALU_SLT: alu_res = ($signed(src_a) < $signed(src_b)) ? 32'd1 : 32'd0;
      ALU_SLL: alu_res = src_b << de_i.shamt; // shifts act on rt
      ALU_SRL: alu_res = src_b >> de_i.shamt;
      default: alu_res = '0;
    endcase
  end

  // jal writes its return address through the normal result path
  assign alu_out = de_i.ctrl.jump[2] ? de_i.pc_plus_4 : alu_res;

  always_comb begin
    if (de_i.ctrl.jump[2])
      write_reg_e_o = 5'd31;
    else if (de_i.ctrl.reg_dst)
      write_reg_e_o = de_i.rd;
    else
      write_reg_e_o = de_i.rt;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      em_o <= '0;
    end else begin
      em_o <= '{
        valid:      de_i.valid,
        ctrl:       '{reg_write:  de_i.ctrl.reg_write,
                      mem_write:  de_i.ctrl.mem_write,
                      mem_to_reg: de_i.ctrl.mem_to_reg},
        alu_out:    alu_out,
        write_data: src_b_reg,
        write_reg:  write_reg_e_o
      };
    end
  end

endmodule : execute

`default_nettype wire

/* rtl/result.sv */
`timescale 1ns/100ps
`default_nettype none

module result #(
  parameter int unsigned DMEM_ADDR_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  mips_pkg::em_t     em_i,
  output mips_pkg::mw_t     mw_o,
  output logic [31:0]       result_w_o,
  output logic              store_valid_o,
  output mips_pkg::store_t  store_o,
  output logic              retire_valid_o,
  output mips_pkg::retire_t retire_o
);

  logic [31:0]            dmem [2**DMEM_ADDR_W];
  logic [DMEM_ADDR_W-1:0] word_addr;
  logic [31:0]            read_data;

  assign word_addr = em_i.alu_out[DMEM_ADDR_W+1:2]; // word accesses only

  always_ff @(posedge clk_i) begin
    if (em_i.valid && em_i.ctrl.mem_write)
      dmem[word_addr] <= em_i.write_data;
  end

  assign read_data = dmem[word_addr];

  assign store_valid_o = em_i.valid & em_i.ctrl.mem_write;
  assign store_o       = '{addr: em_i.alu_out, data: em_i.write_data};

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mw_o <= '0;
    end else begin
      mw_o <= '{
        valid:      em_i.valid,
        reg_write:  em_i.ctrl.reg_write,
        mem_to_reg: em_i.ctrl.mem_to_reg,
        alu_out:    em_i.alu_out,
        read_data:  read_data,
        write_reg:  em_i.write_reg
      };
    end
  end

  assign result_w_o = mw_o.mem_to_reg ? mw_o.read_data : mw_o.alu_out;

  // writes to $0 are dropped by the register file, so they are not reported
  assign retire_valid_o = mw_o.valid & mw_o.reg_write & (mw_o.write_reg != 5'd0);
  assign retire_o       = '{rd: mw_o.write_reg, data: result_w_o};

endmodule : result

`default_nettype wire

/* rtl/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
  input  logic              [4:0] rs_d_i,
  input  logic              [4:0] rt_d_i,
  input  mips_pkg::branch_t       branch_d_i,
  input  logic                    jump_d_i,
  input  mips_pkg::de_t           de_i,
  input  logic              [4:0] write_reg_e_i,
  input  mips_pkg::em_t           em_i,
  input  mips_pkg::mw_t           mw_i,
  output logic                    stall_f_o,
  output logic                    stall_d_o,
  output logic                    flush_e_o,
  output logic                    forward_a_d_o,
  output logic                    forward_b_d_o,
  output mips_pkg::fwd_e_t        forward_a_e_o,
  output mips_pkg::fwd_e_t        forward_b_e_o
);

  import mips_pkg::*;

  // memory stage is newer than writeback, so it wins
  function automatic fwd_e_t fwd_sel(input logic [4:0] src, input logic em_wr,
                                     input logic [4:0] em_dst, input logic mw_wr,
                                     input logic [4:0] mw_dst);
    if (em_wr && em_dst == src)
      return FWD_MEM;
    if (mw_wr && mw_dst == src)
      return FWD_WB;
    return FWD_REG;
  endfunction

  logic em_wr;
  logic mw_wr;
  logic e_hit_d;
  logic m_hit_d;
  logic lw_stall;
  logic branch_stall;

  assign em_wr = em_i.valid & em_i.ctrl.reg_write & (em_i.write_reg != 5'd0);
  assign mw_wr = mw_i.valid & mw_i.reg_write & (mw_i.write_reg != 5'd0);

  assign forward_a_e_o = fwd_sel(de_i.rs, em_wr, em_i.write_reg, mw_wr, mw_i.write_reg);
  assign forward_b_e_o = fwd_sel(de_i.rt, em_wr, em_i.write_reg, mw_wr, mw_i.write_reg);

  assign forward_a_d_o = em_wr & (em_i.write_reg == rs_d_i);
  assign forward_b_d_o = em_wr & (em_i.write_reg == rt_d_i);

  assign e_hit_d = (write_reg_e_i != 5'd0) &
                   ((write_reg_e_i == rs_d_i) | (write_reg_e_i == rt_d_i));
  assign m_hit_d = (em_i.write_reg != 5'd0) &
                   ((em_i.write_reg == rs_d_i) | (em_i.write_reg == rt_d_i));

  // jumps read no registers and never wait
  assign lw_stall     = ~jump_d_i & de_i.valid & de_i.ctrl.mem_to_reg & e_hit_d;
  assign branch_stall = (branch_d_i != 2'b00) &
                        ((de_i.valid & de_i.ctrl.reg_write & e_hit_d) |
                         (em_i.valid & em_i.ctrl.mem_to_reg & m_hit_d));

  assign stall_f_o = lw_stall | branch_stall;
  assign stall_d_o = lw_stall | branch_stall;
  assign flush_e_o = lw_stall | branch_stall; // bubble into execute while decode waits

endmodule : hazard_unit

`default_nettype wire

/* rtl/mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_core #(
  parameter int unsigned DMEM_ADDR_W = 8
) (
  input  logic              clk_i,
  input  logic              arst_n_i,
  output logic [31:0]       imem_addr_o,
  input  logic [31:0]       imem_data_i,
  output logic              retire_valid_o,
  output mips_pkg::retire_t retire_o,
  output logic              store_valid_o,
  output mips_pkg::store_t  store_o
);

  import mips_pkg::*;

  fd_t         fd;
  de_t         de;
  em_t         em;
  mw_t         mw;
  branch_t     branch_d;
  fwd_e_t      forward_a_e;
  fwd_e_t      forward_b_e;
  logic        pc_src;
  logic        jump;
  logic        stall_f;
  logic        stall_d;
  logic        flush_e;
  logic        forward_a_d;
  logic        forward_b_d;
  logic [31:0] pc_branch;
  logic [31:0] jump_target;
  logic [31:0] result_w;
  logic [4:0]  rs_d;
  logic [4:0]  rt_d;
  logic [4:0]  write_reg_e;

  fetch u_fetch (
    .clk_i,
    .arst_n_i,
    .stall_f_i(stall_f),
    .stall_d_i(stall_d),
    .pc_src_i(pc_src),
    .pc_branch_i(pc_branch),
    .jump_i(jump),
    .jump_target_i(jump_target),
    .imem_addr_o,
    .imem_data_i,
    .fd_o(fd)
  );

  decode u_decode (
    .clk_i,
    .arst_n_i,
    .fd_i(fd),
    .alu_out_m_i(em.alu_out),
    .reg_write_w_i(mw.reg_write), // already cleared for bubbles
    .write_reg_w_i(mw.write_reg),
    .result_w_i(result_w),
    .forward_a_d_i(forward_a_d),
    .forward_b_d_i(forward_b_d),
    .flush_e_i(flush_e),
    .branch_o(branch_d),
    .pc_src_o(pc_src),
    .pc_branch_o(pc_branch),
    .jump_o(jump),
    .jump_target_o(jump_target),
    .rs_d_o(rs_d),
    .rt_d_o(rt_d),
    .de_o(de)
  );

  execute u_execute (
    .clk_i,
    .arst_n_i,
    .de_i(de),
    .forward_a_e_i(forward_a_e),
    .forward_b_e_i(forward_b_e),
    .alu_out_m_i(em.alu_out),
    .result_w_i(result_w),
    .em_o(em),
    .write_reg_e_o(write_reg_e)
  );

  result #(
    .DMEM_ADDR_W(DMEM_ADDR_W)
  ) u_result (
    .clk_i,
    .arst_n_i,
    .em_i(em),
    .mw_o(mw),
    .result_w_o(result_w),
    .store_valid_o,
    .store_o,
    .retire_valid_o,
    .retire_o
  );

  hazard_unit u_hazard_unit (
    .rs_d_i(rs_d),
    .rt_d_i(rt_d),
    .branch_d_i(branch_d),
    .jump_d_i(jump),
    .de_i(de),
    .write_reg_e_i(write_reg_e),
    .em_i(em),
    .mw_i(mw),
    .stall_f_o(stall_f),
    .stall_d_o(stall_d),
    .flush_e_o(flush_e),
    .forward_a_d_o(forward_a_d),
    .forward_b_d_o(forward_b_d),
    .forward_a_e_o(forward_a_e),
    .forward_b_e_o(forward_b_e)
  );

endmodule : mips_core

`default_nettype wire

/* test/tb_mips_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

  import mips_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int ROM_WORDS  = 256;
  localparam int DRAIN      = 8;

  logic        clk_i;
  logic        arst_n_i;
  logic [31:0] imem_addr_o;
  logic [31:0] imem_data_i;
  logic        retire_valid_o;
  retire_t     retire_o;
  logic        store_valid_o;
  store_t      store_o;

  logic [31:0] rom [ROM_WORDS];
  retire_t     exp_retire [$];
  store_t      exp_store [$];
  int          stored [$];   // byte addresses the current program has written
  integer      seed;
  int          n;
  logic [4:0]  last_rd;
  logic [4:0]  prev_rd;
  string       test_name;
  int          errors;
  int          retires_seen;
  int          stores_seen;
  time         deadline = 64'd1000000;

  mips_core #(
    .DMEM_ADDR_W(8)
  ) mips_core_inst (
    .clk_i,
    .arst_n_i,
    .imem_addr_o,
    .imem_data_i,
    .retire_valid_o,
    .retire_o,
    .store_valid_o,
    .store_o
  );

  assign imem_data_i = rom[imem_addr_o[9:2]];

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic int pick(input int range);
    return int'($unsigned($random(seed)) % range);
  endfunction

  function automatic logic [31:0] r_word(input funct_e f, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt,
                                         input logic [4:0] shamt);
    return {R_TYPE, rs, rt, rd, shamt, f};
  endfunction

  function automatic logic [31:0] i_word(input opcode_e op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] j_word(input opcode_e op, input int target);
    return {op, 26'(target)};
  endfunction

  task automatic emit(input logic [31:0] word);
    rom[n] = word;
    n++;
  endtask

  task automatic emit_alu(input bit zero_bias);
    logic [4:0] rd;
    logic [4:0] rs;
    logic [4:0] rt;
    rd = 5'(pick(8));
    rs = (pick(2) == 0) ? last_rd : 5'(pick(8)); // lean on the newest results
    rt = (pick(2) == 0) ? prev_rd : 5'(pick(8));
    if (zero_bias && pick(2) == 0)
      rd = 5'd0;
    if (zero_bias && pick(2) == 0)
      rs = 5'd0;
    case (pick(9))
      0:       emit(r_word(F_ADD, rd, rs, rt, 5'd0));
      1:       emit(r_word(F_SUB, rd, rs, rt, 5'd0));
      2:       emit(r_word(F_AND, rd, rs, rt, 5'd0));
      3:       emit(r_word(F_OR, rd, rs, rt, 5'd0));
      4:       emit(r_word(F_SLT, rd, rs, rt, 5'd0));
      5:       emit(r_word(F_SLL, rd, 5'd0, rt, 5'(pick(32))));
      6:       emit(r_word(F_SRL, rd, 5'd0, rt, 5'(pick(32))));
      7:       emit(i_word(ADDI, rd, rs, 16'(pick(65536))));
      default: emit(i_word(ORI, rd, rs, 16'(pick(65536))));
    endcase
    prev_rd = last_rd;
    last_rd = rd;
  endtask

  task automatic emit_sw();
    int         addr;
    logic [4:0] rt;
    addr = 4 * pick(64);
    rt   = (pick(2) == 0) ? last_rd : 5'(pick(8));
    emit(i_word(SW, rt, 5'd0, 16'(addr)));
    stored.push_back(addr);
  endtask

  task automatic emit_lw(input logic [4:0] rt);
    int addr;
    addr = (pick(2) == 0) ? stored[$] : stored[pick(stored.size())];
    emit(i_word(LW, rt, 5'd0, 16'(addr)));
    prev_rd = last_rd;
    last_rd = rt;
  endtask

  task automatic build_program(input int kind);
    int         skip;
    logic [4:0] rs;
    logic [4:0] rt;
    n = 0;
    stored.delete();
    last_rd = 5'd1;
    prev_rd = 5'd2;
    for (int i = 0; i < ROM_WORDS; i++)
      rom[i] = j_word(J, i); // a stray fetch parks on itself
    for (int r = 1; r < 8; r++)
      emit(i_word((pick(2) == 0) ? ADDI : ORI, 5'(r), 5'd0, 16'(pick(65536))));
    case (kind)
      0: repeat (40) emit_alu(1'b0);
      1: repeat (10) begin
        emit_alu(1'b0);
        emit_sw();
        emit_lw(5'(1 + pick(7)));
        emit(r_word(F_ADD, 5'(1 + pick(7)), last_rd, 5'(pick(8)), 5'd0));
        if (pick(2) == 0)
          emit_sw();
      end
      2: begin
        repeat (6) emit_sw();
        repeat (20) begin
          case (pick(3))
            0: emit_alu(1'b0);
            1: emit_lw(5'(1 + pick(7)));
            default: begin
              // copy the newest value so the branch can see equal operands
              rt = 5'(1 + pick(7));
              emit(i_word(ADDI, rt, last_rd, 16'd0));
              prev_rd = last_rd;
              last_rd = rt;
            end
          endcase
          rs   = last_rd;
          rt   = (pick(2) == 0) ? prev_rd : 5'(pick(8));
          skip = 1 + pick(3);
          emit(i_word((pick(2) == 0) ? BEQ : BNE, rt, rs, 16'(skip)));
          repeat (skip) emit_alu(1'b0);
        end
      end
      3: repeat (10) begin
        emit_alu(1'b0);
        skip = 1 + pick(3);
        emit(j_word((pick(2) == 0) ? J : JAL, n + 1 + skip));
        repeat (skip) emit_alu(1'b0);
        emit(r_word(F_ADD, 5'(1 + pick(7)), 5'd31, last_rd, 5'd0)); // reads the link
      end
      default: begin
        repeat (20) emit_alu(1'b1);
        emit_sw();
        emit_lw(5'd0);
        emit(r_word(F_OR, 5'(1 + pick(7)), 5'd0, 5'd0, 5'd0));
        emit(i_word(ADDI, 5'(1 + pick(7)), 5'd0, 16'(pick(65536))));
      end
    endcase
    emit(j_word(J, n)); // end of program
  endtask

  // ISA reference: one instruction at a time in program order, no delay slot
  function automatic void run_model();
    logic [31:0] regs [32];
    logic [31:0] mem [int];
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    logic [4:0]  dst;
    bit          wr;
    int          steps;
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
    pc    = '0;
    steps = 0;
    exp_retire.delete();
    exp_store.delete();
    while (steps < 1000) begin
      instr   = rom[pc[9:2]];
      a       = regs[instr[25:21]];
      b       = regs[instr[20:16]];
      imm     = {{16{instr[15]}}, instr[15:0]};
      next_pc = pc + 32'd4;
      dst     = instr[20:16];
      wr      = 1'b0;
      res     = '0;
      case (instr[31:26])
        R_TYPE: begin
          wr  = 1'b1;
          dst = instr[15:11];
          case (instr[5:0])
            F_ADD:   res = a + b;
            F_SUB:   res = a - b;
            F_AND:   res = a & b;
            F_OR:    res = a | b;
            F_SLT:   res = {31'd0, $signed(a) < $signed(b)};
            F_SLL:   res = b << instr[10:6];
            F_SRL:   res = b >> instr[10:6];
            default: wr = 1'b0;
          endcase
        end
        ADDI: begin
          wr  = 1'b1;
          res = a + imm;
        end
        ORI: begin
          wr  = 1'b1;
          res = a | {16'h0000, instr[15:0]};
        end
        LW: begin
          wr  = 1'b1;
          res = mem.exists(int'(a + imm)) ? mem[int'(a + imm)] : 'x;
        end
        SW: begin
          mem[int'(a + imm)] = b;
          exp_store.push_back(store_t'{addr: a + imm, data: b});
        end
        BEQ: if (a == b) next_pc = pc + 32'd4 + (imm << 2);
        BNE: if (a != b) next_pc = pc + 32'd4 + (imm << 2);
        J, JAL: begin
          next_pc = {next_pc[31:28], instr[25:0], 2'b00};
          if (instr[31:26] == JAL) begin
            wr  = 1'b1;
            dst = 5'd31;
            res = pc + 32'd4;
          end
        end
        default: ;
      endcase
      if (wr && dst != 5'd0) begin
        regs[dst] = res;
        exp_retire.push_back(retire_t'{rd: dst, data: res});
      end
      if (next_pc == pc)
        break; // the closing jump to itself
      pc = next_pc;
      steps++;
    end
  endfunction

  task automatic check_retire(input retire_t exp, input retire_t act);
    retires_seen++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: register write expected $%0d = %h, actual $%0d = %h",
               test_name, exp.rd, exp.data, act.rd, act.data);
    end
  endtask

  task automatic check_store(input store_t exp, input store_t act);
    stores_seen++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: store expected [%h] = %h, actual [%h] = %h",
               test_name, exp.addr, exp.data, act.addr, act.data);
    end
  endtask

  task automatic check_fetch(input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: fetch address expected %h, actual %h", test_name, exp, act);
    end
  endtask

  always @(posedge clk_i) begin
    if (!arst_n_i) begin
      if (retire_valid_o || store_valid_o) begin
        errors++;
        $display("ERROR %s: a report came out while reset was held", test_name);
      end
    end else begin
      if (retire_valid_o) begin
        if (exp_retire.size() == 0) begin
          errors++;
          $display("ERROR %s: register write of $%0d = %h was not expected",
                   test_name, retire_o.rd, retire_o.data);
        end else begin
          check_retire(exp_retire.pop_front(), retire_o);
        end
      end
      if (store_valid_o) begin
        if (exp_store.size() == 0) begin
          errors++;
          $display("ERROR %s: store to %h was not expected", test_name, store_o.addr);
        end else begin
          check_store(exp_store.pop_front(), store_o);
        end
      end
    end
  end

  task automatic run_test(input int kind, input string name);
    int err_start;
    int ret_start;
    int st_start;
    @(negedge clk_i);
    arst_n_i  = 1'b0;
    test_name = name;
    err_start = errors;
    ret_start = retires_seen;
    st_start  = stores_seen;
    build_program(kind);
    run_model();
    deadline = $time + (4 * (n * 3) + 4 + DRAIN) * CLK_PERIOD;
    repeat (4) @(negedge clk_i);
    arst_n_i = 1'b1;
    check_fetch(32'd0, imem_addr_o);
    while (exp_retire.size() != 0 || exp_store.size() != 0)
      @(negedge clk_i);
    repeat (DRAIN) @(negedge clk_i); // anything extra shows up here
    $display("%s: %0d register writes, %0d stores, %0d errors", name,
             retires_seen - ret_start, stores_seen - st_start, errors - err_start);
  endtask

  initial begin
    while ($time <= deadline)
      @(negedge clk_i);
    $display("test %s did not finish in time, %0d register writes and %0d stores never came out",
             test_name, exp_retire.size(), exp_store.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    arst_n_i     = 1'b0;
    seed         = 32'h77d919d4;
    errors       = 0;
    retires_seen = 0;
    stores_seen  = 0;
    n            = 0;
    test_name    = "reset";
    for (int i = 0; i < ROM_WORDS; i++)
      rom[i] = j_word(J, i);
    run_test(0, "alu_forwarding");
    run_test(1, "load_use");
    run_test(2, "branches");
    run_test(3, "jumps");
    run_test(4, "zero_register");
    $display("5 tests, %0d register writes and %0d stores checked, %0d errors",
             retires_seen, stores_seen, errors);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule : tb_mips_core

`default_nettype wire

/* tb.f */
rtl/mips_pkg.sv
rtl/control_unit.sv
rtl/reg_file.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/result.sv
rtl/hazard_unit.sv
rtl/mips_core.sv
test/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - rtl/mips_pkg.sv
  - rtl/control_unit.sv
  - rtl/reg_file.sv
  - rtl/fetch.sv
  - rtl/decode.sv
  - rtl/execute.sv
  - rtl/result.sv
  - rtl/hazard_unit.sv
  - rtl/mips_core.sv
  - target: test
    files:
      - test/tb_mips_core.sv
